/* src/rvfi_chk_pkg.sv */
// RVFI checker shared constants
`default_nettype none

package rvfi_chk_pkg;

  //////////////////////////////////////////////////////////////////////
  // Check indices
  //////////////////////////////////////////////////////////////////////

  // Width of every violation vector in the subsystem
  localparam int NUM_CHECKS = 8;

  // Bit positions inside the violation vectors and the STATUS register
  localparam int CHK_IRQ_FOLLOW  = 0;
  localparam int CHK_DBG_ACK     = 1;
  localparam int CHK_TRAP_INTR   = 2;
  localparam int CHK_TRAP_DBG    = 3;
  localparam int CHK_MCAUSE      = 4;
  localparam int CHK_STEP_CAUSE  = 5;
  localparam int CHK_STEP_ENTRY  = 6;
  localparam int CHK_NMI_HANDLER = 7;

  //////////////////////////////////////////////////////////////////////
  // Debug, NMI and CSR encodings
  //////////////////////////////////////////////////////////////////////

  // Debug cause reported for a single step entry
  localparam logic [2:0] DBG_CAUSE_STEP = 3'd4;

  // The NMI handler sits at this vector slot of mtvec
  localparam logic [4:0] NMI_MTVEC_INDEX = 5'd15;

  // The only mcause codes an NMI may report
  localparam logic [10:0] INT_CAUSE_LOAD_FAULT  = 11'd1024;
  localparam logic [10:0] INT_CAUSE_STORE_FAULT = 11'd1025;

  // Field positions in the dcsr word
  localparam int DCSR_STEP_BIT = 2;
  localparam int DCSR_NMIP_BIT = 3;

  //////////////////////////////////////////////////////////////////////
  // Register map
  //////////////////////////////////////////////////////////////////////

  localparam logic [1:0] REG_ADDR_ENABLE = 2'd0;
  localparam logic [1:0] REG_ADDR_STATUS = 2'd1;
  localparam logic [1:0] REG_ADDR_COUNT  = 2'd2;
  localparam logic [1:0] REG_ADDR_FIRST  = 2'd3;

endpackage

`default_nettype wire

/* src/rvfi_ack_tracker.sv */
// Interrupt and debug acknowledge tracker
`timescale 1ns/1ns
`default_nettype none

module rvfi_ack_tracker (
  input  wire                                   clk_i,
  input  wire                                   rst_ni,
  // Retirement trace
  input  wire                                   rvfi_valid_i,
  input  wire                                   rvfi_intr_i,
  input  wire                                   rvfi_trap_exc_i,
  input  wire                                   rvfi_trap_dbg_i,
  input  wire  [2:0]                            rvfi_dbg_i,
  // Acknowledge strobes from the core
  input  wire                                   irq_ack_i,
  input  wire                                   dbg_ack_i,
  output logic [rvfi_chk_pkg::NUM_CHECKS-1:0]   viol_o
);

  // Set between an irq_ack and the retirement that must show it
  logic       irq_pend_q;
  // Number of debug acknowledges not yet seen on the trace
  logic [1:0] dbg_cnt_q;
  logic       dbg_ret;
  logic       irq_viol_q;
  logic       dbg_viol_q;

  // A retirement that reports debug entry
  assign dbg_ret = rvfi_valid_i && (rvfi_dbg_i != 3'd0);

  //////////////////////////////////////////////////////////////////////
  // Interrupt acknowledge follow-up
  //////////////////////////////////////////////////////////////////////

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      irq_pend_q <= 1'b0;
      irq_viol_q <= 1'b0;
    end else begin
      // Only a retirement after the acknowledge cycle is checked
      irq_viol_q <= rvfi_valid_i && irq_pend_q &&
                    !(rvfi_intr_i || rvfi_trap_dbg_i || rvfi_trap_exc_i);
      if (irq_ack_i) begin
        irq_pend_q <= 1'b1;
      end else if (rvfi_valid_i) begin
        irq_pend_q <= 1'b0;
      end
    end
  end

  //////////////////////////////////////////////////////////////////////
  // Debug acknowledge accounting
  //////////////////////////////////////////////////////////////////////

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      dbg_cnt_q  <= 2'd0;
      dbg_viol_q <= 1'b0;
    end else begin
      // Debug entry on the trace with nothing acknowledged before it
      dbg_viol_q <= dbg_ret && (dbg_cnt_q == 2'd0);
      // Counter saturates at both ends
      if (dbg_ack_i && !dbg_ret && (dbg_cnt_q != 2'd3)) begin
        dbg_cnt_q <= dbg_cnt_q + 2'd1;
      end else if (dbg_ret && !dbg_ack_i && (dbg_cnt_q != 2'd0)) begin
        dbg_cnt_q <= dbg_cnt_q - 2'd1;
      end
    end
  end

  // Only this checker's own positions are ever set
  always_comb begin
    viol_o                              = '0;
    viol_o[rvfi_chk_pkg::CHK_IRQ_FOLLOW] = irq_viol_q;
    viol_o[rvfi_chk_pkg::CHK_DBG_ACK]    = dbg_viol_q;
  end

endmodule

`default_nettype wire

/* src/rvfi_trap_follow.sv */
// Trap follow-up checker
`timescale 1ns/1ns
`default_nettype none

module rvfi_trap_follow (
  input  wire                                   clk_i,
  input  wire                                   rst_ni,
  // Retirement trace
  input  wire                                   rvfi_valid_i,
  input  wire                                   rvfi_intr_i,
  input  wire                                   rvfi_trap_i,
  input  wire                                   rvfi_trap_exc_i,
  input  wire                                   rvfi_trap_dbg_i,
  input  wire  [5:0]                            rvfi_trap_exc_cause_i,
  input  wire  [2:0]                            rvfi_trap_dbg_cause_i,
  input  wire  [2:0]                            rvfi_dbg_i,
  input  wire  [31:0]                           rvfi_pc_i,
  input  wire  [31:0]                           rvfi_dcsr_i,
  input  wire  [31:0]                           rvfi_mcause_i,
  // Core state seen between retirements
  input  wire  [24:0]                           mtvec_addr_i,
  input  wire                                   debug_mode_i,
  input  wire                                   pending_nmi_i,
  output logic [rvfi_chk_pkg::NUM_CHECKS-1:0]   viol_o
);

  // Set once the first retirement after reset has been recorded
  logic        seen_q;
  // What the previous retirement reported
  logic        trap_q;
  logic        dbg_trap_q;
  logic        nmip_q;
  logic [5:0]  exc_cause_q;
  logic [2:0]  dbg_cause_q;
  // Guards accumulated since the previous retirement
  logic        nodbg_q;
  logic        nonmi_q;
  logic [24:0] mtvec_prev_q;
  logic        nodbg_c;
  logic        nonmi_c;
  logic        nodbg_ok;
  logic        nonmi_ok;
  logic        follow;
  logic [31:0] nmi_pc;
  logic        nmi_cause_ok;
  logic        nmi_entry_ok;
  logic [rvfi_chk_pkg::NUM_CHECKS-1:0] viol_d;
  logic [rvfi_chk_pkg::NUM_CHECKS-1:0] viol_q;

  //////////////////////////////////////////////////////////////////////
  // Guard conditions
  //////////////////////////////////////////////////////////////////////

  // Neither in debug mode nor single stepping in this cycle
  assign nodbg_c = !(debug_mode_i || rvfi_dcsr_i[rvfi_chk_pkg::DCSR_STEP_BIT]);
  // Also no NMI pending and mtvec unchanged since the last cycle
  assign nonmi_c = nodbg_c && !pending_nmi_i && (mtvec_addr_i == mtvec_prev_q);

  // The guards must have held from the previous retirement through this cycle
  assign nodbg_ok = nodbg_q && nodbg_c;
  assign nonmi_ok = nonmi_q && nonmi_c;

  // A retirement that has a predecessor to compare against
  assign follow = rvfi_valid_i && seen_q;

  // Expected NMI handler entry
  assign nmi_pc       = {mtvec_addr_i, rvfi_chk_pkg::NMI_MTVEC_INDEX, 2'b00};
  assign nmi_cause_ok = (rvfi_mcause_i[10:0] == rvfi_chk_pkg::INT_CAUSE_LOAD_FAULT) ||
                        (rvfi_mcause_i[10:0] == rvfi_chk_pkg::INT_CAUSE_STORE_FAULT);
  assign nmi_entry_ok = rvfi_intr_i && (rvfi_pc_i == nmi_pc) && nmi_cause_ok;

  //////////////////////////////////////////////////////////////////////
  // Violation decode
  //////////////////////////////////////////////////////////////////////

  always_comb begin
    viol_d = '0;
    // A trap outside debug must be followed by an interrupted retirement
    viol_d[rvfi_chk_pkg::CHK_TRAP_INTR] = follow && trap_q && nodbg_ok && !rvfi_intr_i;
    // A debug trap must be followed by debug entry with the same cause
    viol_d[rvfi_chk_pkg::CHK_TRAP_DBG] = follow && dbg_trap_q &&
        ((rvfi_dbg_i != dbg_cause_q) || (rvfi_dbg_i == 3'd0));
    // mcause must carry the recorded exception code unless an NMI intervened
    viol_d[rvfi_chk_pkg::CHK_MCAUSE] = follow && trap_q && nonmi_ok &&
        (rvfi_mcause_i[5:0] != exc_cause_q);
    // Exception and debug together only happen while stepping
    viol_d[rvfi_chk_pkg::CHK_STEP_CAUSE] = rvfi_valid_i && rvfi_trap_exc_i &&
        rvfi_trap_dbg_i && (rvfi_trap_dbg_cause_i != rvfi_chk_pkg::DBG_CAUSE_STEP);
    // Step entry needs the step cause on the retirement before it
    viol_d[rvfi_chk_pkg::CHK_STEP_ENTRY] = follow &&
        (rvfi_dbg_i == rvfi_chk_pkg::DBG_CAUSE_STEP) &&
        (dbg_cause_q != rvfi_chk_pkg::DBG_CAUSE_STEP) && !rvfi_intr_i;
    // dcsr.nmip leads straight into the NMI handler
    viol_d[rvfi_chk_pkg::CHK_NMI_HANDLER] = follow && nmip_q && nonmi_ok && !nmi_entry_ok;
  end

  //////////////////////////////////////////////////////////////////////
  // Per retirement record
  //////////////////////////////////////////////////////////////////////

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      seen_q       <= 1'b0;
      trap_q       <= 1'b0;
      dbg_trap_q   <= 1'b0;
      nmip_q       <= 1'b0;
      nodbg_q      <= 1'b0;
      nonmi_q      <= 1'b0;
      mtvec_prev_q <= '0;
      viol_q       <= '0;
    end else begin
      mtvec_prev_q <= mtvec_addr_i;
      viol_q       <= viol_d;
      if (rvfi_valid_i) begin
        seen_q     <= 1'b1;
        trap_q     <= rvfi_trap_i;
        dbg_trap_q <= rvfi_trap_dbg_i;
        nmip_q     <= rvfi_dcsr_i[rvfi_chk_pkg::DCSR_NMIP_BIT];
        // Guards restart with the state of the retiring cycle
        nodbg_q    <= nodbg_c;
        nonmi_q    <= nonmi_c;
      end else begin
        nodbg_q    <= nodbg_q && nodbg_c;
        nonmi_q    <= nonmi_q && nonmi_c;
      end
    end
  end

  // Cause fields of the retiring instruction
  always_ff @(posedge clk_i) begin
    if (rvfi_valid_i) begin
      exc_cause_q <= rvfi_trap_exc_cause_i;
      dbg_cause_q <= rvfi_trap_dbg_cause_i;
    end
  end

  assign viol_o = viol_q;

endmodule

`default_nettype wire

/* src/rvfi_chk_regs.sv */
// Checker result registers
`timescale 1ns/1ns
`default_nettype none

module rvfi_chk_regs #(
  parameter int unsigned CNT_W = 16
) (
  input  wire                                   clk_i,
  input  wire                                   rst_ni,
  input  wire  [rvfi_chk_pkg::NUM_CHECKS-1:0]   viol_i,
  // Register port
  input  wire                                   reg_we_i,
  input  wire  [1:0]                            reg_addr_i,
  input  wire  [31:0]                           reg_wdata_i,
  output logic [31:0]                           reg_rdata_o,
  output logic                                  err_o
);

  localparam int IDX_W           = $clog2(rvfi_chk_pkg::NUM_CHECKS);
  localparam int FIRST_VALID_BIT = 8;

  logic [rvfi_chk_pkg::NUM_CHECKS-1:0] enable_q;
  logic [rvfi_chk_pkg::NUM_CHECKS-1:0] status_q;
  logic [rvfi_chk_pkg::NUM_CHECKS-1:0] viol_en;
  logic [rvfi_chk_pkg::NUM_CHECKS-1:0] clr_mask;
  logic [rvfi_chk_pkg::NUM_CHECKS-1:0] status_kept;
  logic [CNT_W-1:0]                    count_q;
  logic [CNT_W-1:0]                    count_base;
  logic [IDX_W-1:0]                    first_idx_q;
  logic [IDX_W-1:0]                    low_idx;
  logic                                first_valid_q;
  logic                                any_viol;

  assign viol_en  = viol_i & enable_q;
  assign any_viol = |viol_en;

  // Write-one-to-clear mask for STATUS
  assign clr_mask = (reg_we_i && (reg_addr_i == rvfi_chk_pkg::REG_ADDR_STATUS)) ?
                    reg_wdata_i[rvfi_chk_pkg::NUM_CHECKS-1:0] : '0;
  assign status_kept = status_q & ~clr_mask;

  // Any write restarts the counter
  assign count_base = reg_we_i ? '0 : count_q;

  // Lowest enabled violation index of this cycle
  always_comb begin
    low_idx = '0;
    for (int i = rvfi_chk_pkg::NUM_CHECKS - 1; i >= 0; i--) begin
      if (viol_en[i]) begin
        low_idx = IDX_W'(i);
      end
    end
  end

  //////////////////////////////////////////////////////////////////////
  // State update
  //////////////////////////////////////////////////////////////////////

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      enable_q      <= '1;
      status_q      <= '0;
      count_q       <= '0;
      first_idx_q   <= '0;
      first_valid_q <= 1'b0;
    end else begin
      if (reg_we_i && (reg_addr_i == rvfi_chk_pkg::REG_ADDR_ENABLE)) begin
        enable_q <= reg_wdata_i[rvfi_chk_pkg::NUM_CHECKS-1:0];
      end
      // New violations win over a clear in the same cycle
      status_q <= status_kept | viol_en;
      if (any_viol && (count_base != {CNT_W{1'b1}})) begin
        count_q <= count_base + 1'b1;
      end else begin
        count_q <= count_base;
      end
      // FIRST re-arms whenever STATUS has been cleared out
      if (any_viol && (!first_valid_q || (status_kept == '0))) begin
        first_idx_q   <= low_idx;
        first_valid_q <= 1'b1;
      end else if (status_kept == '0) begin
        first_valid_q <= 1'b0;
      end
    end
  end

  // Read mux with the unused upper bits reading as zero
  always_comb begin
    reg_rdata_o = '0;
    case (reg_addr_i)
      rvfi_chk_pkg::REG_ADDR_ENABLE: reg_rdata_o[rvfi_chk_pkg::NUM_CHECKS-1:0] = enable_q;
      rvfi_chk_pkg::REG_ADDR_STATUS: reg_rdata_o[rvfi_chk_pkg::NUM_CHECKS-1:0] = status_q;
      rvfi_chk_pkg::REG_ADDR_COUNT:  reg_rdata_o[CNT_W-1:0] = count_q;
      default: begin
        reg_rdata_o[IDX_W-1:0]       = first_idx_q;
        reg_rdata_o[FIRST_VALID_BIT] = first_valid_q;
      end
    endcase
  end

  assign err_o = |status_q;

endmodule

`default_nettype wire

/* src/rvfi_chk_top.sv */
// RVFI trace checker top level
`timescale 1ns/1ns
`default_nettype none

module rvfi_chk_top #(
  parameter int unsigned CNT_W = 16
) (
  input  wire         clk_i,
  input  wire         rst_ni,
  // Retirement trace
  input  wire         rvfi_valid_i,
  input  wire         rvfi_intr_i,
  input  wire         rvfi_trap_i,
  input  wire         rvfi_trap_exc_i,
  input  wire         rvfi_trap_dbg_i,
  input  wire  [5:0]  rvfi_trap_exc_cause_i,
  input  wire  [2:0]  rvfi_trap_dbg_cause_i,
  input  wire  [2:0]  rvfi_dbg_i,
  input  wire  [31:0] rvfi_pc_i,
  input  wire  [31:0] rvfi_dcsr_i,
  input  wire  [31:0] rvfi_mcause_i,
  // Core side state and strobes
  input  wire  [24:0] mtvec_addr_i,
  input  wire         debug_mode_i,
  input  wire         pending_nmi_i,
  input  wire         irq_ack_i,
  input  wire         dbg_ack_i,
  // Register port
  input  wire         reg_we_i,
  input  wire  [1:0]  reg_addr_i,
  input  wire  [31:0] reg_wdata_i,
  output logic [31:0] reg_rdata_o,
  output logic        err_o
);

  logic [rvfi_chk_pkg::NUM_CHECKS-1:0] viol_ack;
  logic [rvfi_chk_pkg::NUM_CHECKS-1:0] viol_trap;
  logic [rvfi_chk_pkg::NUM_CHECKS-1:0] viol_all;

  rvfi_ack_tracker u_ack_tracker (
    .clk_i           (clk_i),
    .rst_ni          (rst_ni),
    .rvfi_valid_i    (rvfi_valid_i),
    .rvfi_intr_i     (rvfi_intr_i),
    .rvfi_trap_exc_i (rvfi_trap_exc_i),
    .rvfi_trap_dbg_i (rvfi_trap_dbg_i),
    .rvfi_dbg_i      (rvfi_dbg_i),
    .irq_ack_i       (irq_ack_i),
    .dbg_ack_i       (dbg_ack_i),
    .viol_o          (viol_ack)
  );

  rvfi_trap_follow u_trap_follow (
    .clk_i                 (clk_i),
    .rst_ni                (rst_ni),
    .rvfi_valid_i          (rvfi_valid_i),
    .rvfi_intr_i           (rvfi_intr_i),
    .rvfi_trap_i           (rvfi_trap_i),
    .rvfi_trap_exc_i       (rvfi_trap_exc_i),
    .rvfi_trap_dbg_i       (rvfi_trap_dbg_i),
    .rvfi_trap_exc_cause_i (rvfi_trap_exc_cause_i),
    .rvfi_trap_dbg_cause_i (rvfi_trap_dbg_cause_i),
    .rvfi_dbg_i            (rvfi_dbg_i),
    .rvfi_pc_i             (rvfi_pc_i),
    .rvfi_dcsr_i           (rvfi_dcsr_i),
    .rvfi_mcause_i         (rvfi_mcause_i),
    .mtvec_addr_i          (mtvec_addr_i),
    .debug_mode_i          (debug_mode_i),
    .pending_nmi_i         (pending_nmi_i),
    .viol_o                (viol_trap)
  );

  // The checkers own disjoint bit positions
  assign viol_all = viol_ack | viol_trap;

  rvfi_chk_regs #(
    .CNT_W (CNT_W)
  ) u_chk_regs (
    .clk_i       (clk_i),
    .rst_ni      (rst_ni),
    .viol_i      (viol_all),
    .reg_we_i    (reg_we_i),
    .reg_addr_i  (reg_addr_i),
    .reg_wdata_i (reg_wdata_i),
    .reg_rdata_o (reg_rdata_o),
    .err_o       (err_o)
  );

endmodule

`default_nettype wire

/* test/tb_rvfi_chk_tasks.svh */
// Directed checker tests

task automatic reset_and_clean_trace();
  int err_start;
  err_start = errors;
  check_reg(A_ENABLE, "ENABLE", 32'hFF);
  check_reg(A_STATUS, "STATUS", 32'h0);
  check_reg(A_COUNT, "COUNT", 32'h0);
  check_reg(A_FIRST, "FIRST", 32'h0);
  // Acknowledged interrupt shows up on the next retirement
  ack(1'b1, 1'b0);
  retire(1'b1, 1'b0, 1'b0, 6'd0, 3'd0, 3'd0, 11'd0);
  // Acknowledged debug entry
  ack(1'b0, 1'b1);
  retire(1'b0, 1'b0, 1'b0, 6'd0, 3'd0, 3'd1, 11'd0);
  // Trap then interrupted retirement carrying the same cause
  retire(1'b0, 1'b1, 1'b0, 6'd5, 3'd0, 3'd0, 11'd0);
  retire(1'b1, 1'b0, 1'b0, 6'd0, 3'd0, 3'd0, 11'd5);
  settle();
  check_reg(A_STATUS, "STATUS", 32'h0);
  check_reg(A_COUNT, "COUNT", 32'h0);
  check_err(1'b0);
  finish_test("reset_clean", err_start);
endtask

task automatic ack_rule_violations();
  int err_start;
  err_start = errors;
  flush();
  ack(1'b1, 1'b0);
  retire(1'b0, 1'b0, 1'b0, 6'd0, 3'd0, 3'd0, 11'd0);
  settle();
  check_reg(A_STATUS, "STATUS", status_bit(rvfi_chk_pkg::CHK_IRQ_FOLLOW));
  check_err(1'b1);
  check_reg(A_FIRST, "FIRST", first_word(rvfi_chk_pkg::CHK_IRQ_FOLLOW));
  write_reg(A_STATUS, 32'hFF);
  // Debug entry with nothing acknowledged
  retire(1'b0, 1'b0, 1'b0, 6'd0, 3'd0, 3'd1, 11'd0);
  settle();
  check_reg(A_STATUS, "STATUS", status_bit(rvfi_chk_pkg::CHK_DBG_ACK));
  check_reg(A_COUNT, "COUNT", 32'd1);
  check_reg(A_FIRST, "FIRST", first_word(rvfi_chk_pkg::CHK_DBG_ACK));
  finish_test("ack_rules", err_start);
endtask

task automatic trap_follow_up();
  int err_start;
  err_start = errors;
  flush();
  // Follow-up lacks the interrupt and carries cause 3 instead of 7
  retire(1'b0, 1'b1, 1'b0, 6'd7, 3'd0, 3'd0, 11'd0);
  retire(1'b0, 1'b0, 1'b0, 6'd0, 3'd0, 3'd0, 11'd3);
  settle();
  check_reg(A_STATUS, "STATUS", status_bit(rvfi_chk_pkg::CHK_TRAP_INTR) |
                                status_bit(rvfi_chk_pkg::CHK_MCAUSE));
  check_reg(A_COUNT, "COUNT", 32'd1);
  check_reg(A_FIRST, "FIRST", first_word(rvfi_chk_pkg::CHK_TRAP_INTR));
  write_reg(A_STATUS, 32'hFF);
  // Same sequence with debug mode in the gap disables both checks
  retire(1'b0, 1'b1, 1'b0, 6'd7, 3'd0, 3'd0, 11'd0);
  next_cycle();
  debug_mode_i = 1'b1;
  next_cycle();
  debug_mode_i = 1'b0;
  retire(1'b0, 1'b0, 1'b0, 6'd0, 3'd0, 3'd0, 11'd3);
  settle();
  check_reg(A_STATUS, "STATUS", 32'h0);
  check_reg(A_COUNT, "COUNT", 32'h0);
  finish_test("trap_follow", err_start);
endtask

task automatic single_step_rules();
  int err_start;
  err_start = errors;
  flush();
  // Exception and debug trap together with debug cause 1
  retire(1'b0, 1'b1, 1'b1, 6'd2, 3'd1, 3'd0, 11'd0);
  // Legal follow-up so that only the step cause check fires
  ack(1'b0, 1'b1);
  retire(1'b1, 1'b0, 1'b0, 6'd0, 3'd0, 3'd1, 11'd2);
  settle();
  check_reg(A_STATUS, "STATUS", status_bit(rvfi_chk_pkg::CHK_STEP_CAUSE));
  check_reg(A_COUNT, "COUNT", 32'd1);
  check_reg(A_FIRST, "FIRST", first_word(rvfi_chk_pkg::CHK_STEP_CAUSE));
  write_reg(A_STATUS, 32'hFF);
  // Step entry after a retirement whose debug cause was 0
  ack(1'b0, 1'b1);
  retire(1'b0, 1'b0, 1'b0, 6'd0, 3'd0, rvfi_chk_pkg::DBG_CAUSE_STEP, 11'd0);
  settle();
  check_reg(A_STATUS, "STATUS", status_bit(rvfi_chk_pkg::CHK_STEP_ENTRY));
  check_reg(A_FIRST, "FIRST", first_word(rvfi_chk_pkg::CHK_STEP_ENTRY));
  write_reg(A_STATUS, 32'hFF);
  // An interrupted step entry is allowed
  ack(1'b0, 1'b1);
  retire(1'b1, 1'b0, 1'b0, 6'd0, 3'd0, rvfi_chk_pkg::DBG_CAUSE_STEP, 11'd0);
  settle();
  check_reg(A_STATUS, "STATUS", 32'h0);
  check_reg(A_COUNT, "COUNT", 32'h0);
  finish_test("step_rules", err_start);
endtask

task automatic nmi_handler_entry();
  logic [31:0] handler_pc;
  int          err_start;
  err_start  = errors;
  handler_pc = {MTVEC, rvfi_chk_pkg::NMI_MTVEC_INDEX, 2'b00};
  flush();
  retire(1'b0, 1'b0, 1'b0, 6'd0, 3'd0, 3'd0, 11'd0);
  rvfi_dcsr_i = 32'd1 << rvfi_chk_pkg::DCSR_NMIP_BIT;
  // One word past the handler entry
  retire(1'b1, 1'b0, 1'b0, 6'd0, 3'd0, 3'd0, 11'd1024);
  rvfi_pc_i = handler_pc + 32'd4;
  settle();
  check_reg(A_STATUS, "STATUS", status_bit(rvfi_chk_pkg::CHK_NMI_HANDLER));
  check_reg(A_FIRST, "FIRST", first_word(rvfi_chk_pkg::CHK_NMI_HANDLER));
  write_reg(A_STATUS, 32'hFF);
  retire(1'b0, 1'b0, 1'b0, 6'd0, 3'd0, 3'd0, 11'd0);
  rvfi_dcsr_i = 32'd1 << rvfi_chk_pkg::DCSR_NMIP_BIT;
  retire(1'b1, 1'b0, 1'b0, 6'd0, 3'd0, 3'd0, 11'd1024);
  rvfi_pc_i = handler_pc;
  settle();
  check_reg(A_STATUS, "STATUS", 32'h0);
  finish_test("nmi_handler", err_start);
endtask

task automatic register_behavior();
  int err_start;
  err_start = errors;
  flush();
  // Masked interrupt follow-up check
  write_reg(A_ENABLE, 32'hFF & ~status_bit(rvfi_chk_pkg::CHK_IRQ_FOLLOW));
  ack(1'b1, 1'b0);
  retire(1'b0, 1'b0, 1'b0, 6'd0, 3'd0, 3'd0, 11'd0);
  settle();
  check_reg(A_STATUS, "STATUS", 32'h0);
  check_reg(A_COUNT, "COUNT", 32'h0);
  write_reg(A_ENABLE, 32'hFF);
  // Set two sticky bits and clear only one of them
  ack(1'b1, 1'b0);
  retire(1'b0, 1'b0, 1'b0, 6'd0, 3'd0, 3'd0, 11'd0);
  retire(1'b0, 1'b0, 1'b0, 6'd0, 3'd0, 3'd1, 11'd0);
  settle();
  write_reg(A_STATUS, status_bit(rvfi_chk_pkg::CHK_IRQ_FOLLOW));
  check_reg(A_STATUS, "STATUS", status_bit(rvfi_chk_pkg::CHK_DBG_ACK));
  // The earlier interrupt violation stays recorded as the first one
  check_reg(A_FIRST, "FIRST", first_word(rvfi_chk_pkg::CHK_IRQ_FOLLOW));
  // Unacknowledged debug entries raise one violation per cycle
  repeat (CNT_MAX + 5) begin
    retire(1'b0, 1'b0, 1'b0, 6'd0, 3'd0, 3'd1, 11'd0);
  end
  settle();
  check_reg(A_COUNT, "COUNT", 32'(CNT_MAX));
  write_reg(A_COUNT, 32'h0);
  check_reg(A_COUNT, "COUNT", 32'h0);
  finish_test("reg_behavior", err_start);
endtask

/* test/tb_rvfi_chk.sv */
// RVFI trace checker testbench
`timescale 1ns/1ns
`default_nettype none

module tb_rvfi_chk;

  localparam int CLK_PERIOD      = 40;
  localparam int CNT_W           = 8;
  localparam int CNT_MAX         = (1 << CNT_W) - 1;
  localparam int NUM_TESTS       = 6;
  localparam int CYCLES_PER_TEST = 200;
  localparam logic [24:0] MTVEC  = 25'h0123456;
  localparam logic [1:0] A_ENABLE = rvfi_chk_pkg::REG_ADDR_ENABLE;
  localparam logic [1:0] A_STATUS = rvfi_chk_pkg::REG_ADDR_STATUS;
  localparam logic [1:0] A_COUNT  = rvfi_chk_pkg::REG_ADDR_COUNT;
  localparam logic [1:0] A_FIRST  = rvfi_chk_pkg::REG_ADDR_FIRST;

  logic        clk_i;
  logic        rst_ni;
  logic        rvfi_valid_i;
  logic        rvfi_intr_i;
  logic        rvfi_trap_i;
  logic        rvfi_trap_exc_i;
  logic        rvfi_trap_dbg_i;
  logic [5:0]  rvfi_trap_exc_cause_i;
  logic [2:0]  rvfi_trap_dbg_cause_i;
  logic [2:0]  rvfi_dbg_i;
  logic [31:0] rvfi_pc_i;
  logic [31:0] rvfi_dcsr_i;
  logic [31:0] rvfi_mcause_i;
  logic [24:0] mtvec_addr_i;
  logic        debug_mode_i;
  logic        pending_nmi_i;
  logic        irq_ack_i;
  logic        dbg_ack_i;
  logic        reg_we_i;
  logic [1:0]  reg_addr_i;
  logic [31:0] reg_wdata_i;
  logic [31:0] reg_rdata_o;
  logic        err_o;

  // Galois LFSR state for filler fields
  logic [31:0] lfsr_q;
  int          errors;
  int          tests_run;

  rvfi_chk_top #(
    .CNT_W (CNT_W)
  ) dut0 (
    .clk_i                 (clk_i),
    .rst_ni                (rst_ni),
    .rvfi_valid_i          (rvfi_valid_i),
    .rvfi_intr_i           (rvfi_intr_i),
    .rvfi_trap_i           (rvfi_trap_i),
    .rvfi_trap_exc_i       (rvfi_trap_exc_i),
    .rvfi_trap_dbg_i       (rvfi_trap_dbg_i),
    .rvfi_trap_exc_cause_i (rvfi_trap_exc_cause_i),
    .rvfi_trap_dbg_cause_i (rvfi_trap_dbg_cause_i),
    .rvfi_dbg_i            (rvfi_dbg_i),
    .rvfi_pc_i             (rvfi_pc_i),
    .rvfi_dcsr_i           (rvfi_dcsr_i),
    .rvfi_mcause_i         (rvfi_mcause_i),
    .mtvec_addr_i          (mtvec_addr_i),
    .debug_mode_i          (debug_mode_i),
    .pending_nmi_i         (pending_nmi_i),
    .irq_ack_i             (irq_ack_i),
    .dbg_ack_i             (dbg_ack_i),
    .reg_we_i              (reg_we_i),
    .reg_addr_i            (reg_addr_i),
    .reg_wdata_i           (reg_wdata_i),
    .reg_rdata_o           (reg_rdata_o),
    .err_o                 (err_o)
  );

  always #(CLK_PERIOD / 2) clk_i = ~clk_i;

  //////////////////////////////////////////////////////////////////////
  // Stimulus helpers
  //////////////////////////////////////////////////////////////////////

  // Steps the LFSR once per bit and shifts each output bit in
  function automatic logic [31:0] lfsr_bits(input int n);
    logic [31:0] val;
    val = '0;
    for (int i = 0; i < n; i++) begin
      val = {val[30:0], lfsr_q[0]};
      if (lfsr_q[0]) begin
        lfsr_q = (lfsr_q >> 1) ^ 32'hD000_0001;
      end else begin
        lfsr_q = lfsr_q >> 1;
      end
    end
    return val;
  endfunction

  // Expected STATUS word with one check bit set
  function automatic logic [31:0] status_bit(input int idx);
    return 32'd1 << idx;
  endfunction

  // Expected FIRST word with the index and the valid bit at position 8
  function automatic logic [31:0] first_word(input int idx);
    return 32'h100 | 32'(idx);
  endfunction

  // Per-cycle strobes and trace fields go back to idle
  task automatic idle_inputs();
    rvfi_valid_i          = 1'b0;
    rvfi_intr_i           = 1'b0;
    rvfi_trap_i           = 1'b0;
    rvfi_trap_exc_i       = 1'b0;
    rvfi_trap_dbg_i       = 1'b0;
    rvfi_trap_exc_cause_i = '0;
    rvfi_trap_dbg_cause_i = '0;
    rvfi_dbg_i            = '0;
    rvfi_pc_i             = '0;
    rvfi_dcsr_i           = '0;
    rvfi_mcause_i         = '0;
    irq_ack_i             = 1'b0;
    dbg_ack_i             = 1'b0;
    reg_we_i              = 1'b0;
    reg_wdata_i           = '0;
  endtask

  // All driving starts right after a falling edge
  task automatic next_cycle();
    @(negedge clk_i);
    idle_inputs();
  endtask

  task automatic retire(input logic intr, input logic exc, input logic dtrap,
                        input logic [5:0] exc_cause, input logic [2:0] dbg_cause,
                        input logic [2:0] dbg, input logic [10:0] mcause_lo);
    logic [31:0] pc_fill;
    logic [31:0] mcause_fill;
    next_cycle();
    pc_fill               = lfsr_bits(30);
    mcause_fill           = lfsr_bits(21);
    rvfi_valid_i          = 1'b1;
    rvfi_intr_i           = intr;
    rvfi_trap_i           = exc | dtrap;
    rvfi_trap_exc_i       = exc;
    rvfi_trap_dbg_i       = dtrap;
    rvfi_trap_exc_cause_i = exc_cause;
    rvfi_trap_dbg_cause_i = dbg_cause;
    rvfi_dbg_i            = dbg;
    rvfi_pc_i             = {pc_fill[29:0], 2'b00};
    rvfi_mcause_i         = {mcause_fill[20:0], mcause_lo};
  endtask

  task automatic ack(input logic irq, input logic dbg);
    next_cycle();
    irq_ack_i = irq;
    dbg_ack_i = dbg;
  endtask

  task automatic write_reg(input logic [1:0] addr, input logic [31:0] data);
    next_cycle();
    reg_we_i    = 1'b1;
    reg_addr_i  = addr;
    reg_wdata_i = data;
    next_cycle();
  endtask

  // Violations reach the registers two edges after the retirement
  task automatic settle();
    repeat (3) next_cycle();
  endtask

  // Reads are combinational and are sampled in the middle of the low phase
  task automatic check_reg(input logic [1:0] addr, input string name,
                           input logic [31:0] exp);
    next_cycle();
    reg_addr_i = addr;
    #(CLK_PERIOD / 4);
    if (reg_rdata_o !== exp) begin
      $display("** Error at %0t ns: %s expected 0x%08h, read 0x%08h",
               $time, name, exp, reg_rdata_o);
      errors++;
    end
  endtask

  // The error level is sampled at the same point as a register read
  task automatic check_err(input logic exp);
    if (err_o !== exp) begin
      $display("** Error at %0t ns: err_o expected %b, read %b", $time, exp, err_o);
      errors++;
    end
  endtask

  // Plain retirement retires any pending record, then results are cleared
  task automatic flush();
    retire(1'b0, 1'b0, 1'b0, 6'd0, 3'd0, 3'd0, 11'd0);
    settle();
    write_reg(A_STATUS, 32'hFF);
  endtask

  task automatic finish_test(input string name, input int err_start);
    tests_run++;
    if (errors == err_start) begin
      $display("%s: passed", name);
    end else begin
      $display("%s: %0d mismatches", name, errors - err_start);
    end
  endtask

  `include "tb_rvfi_chk_tasks.svh"

  //////////////////////////////////////////////////////////////////////
  // Test sequence and watchdog
  //////////////////////////////////////////////////////////////////////

  initial begin
    lfsr_q        = 32'd57;
    errors        = 0;
    tests_run     = 0;
    clk_i         = 1'b0;
    rst_ni        = 1'b0;
    reg_addr_i    = '0;
    mtvec_addr_i  = MTVEC;
    debug_mode_i  = 1'b0;
    pending_nmi_i = 1'b0;
    idle_inputs();
    repeat (2) @(negedge clk_i);
    rst_ni = 1'b1;
    reset_and_clean_trace();
    ack_rule_violations();
    trap_follow_up();
    single_step_rules();
    nmi_handler_entry();
    register_behavior();
    $display("Tests run: %0d, errors: %0d", tests_run, errors);
    if (errors == 0) begin
      $display("TEST PASS");
    end else begin
      $display("TEST FAIL");
    end
    $finish;
  end

  initial begin
    #(CLK_PERIOD * NUM_TESTS * CYCLES_PER_TEST);
    $display("Watchdog expired before the test sequence completed");
    $display("TEST FAIL");
    $finish;
  end

endmodule

`default_nettype wire

/* verilog.f */
+incdir+test
src/rvfi_chk_pkg.sv
src/rvfi_ack_tracker.sv
src/rvfi_trap_follow.sv
src/rvfi_chk_regs.sv
src/rvfi_chk_top.sv
test/tb_rvfi_chk.sv

/* Bender.yml */
package:
  name: rvfi_chk

sources:
  - files:
      - src/rvfi_chk_pkg.sv
      - src/rvfi_ack_tracker.sv
      - src/rvfi_trap_follow.sv
      - src/rvfi_chk_regs.sv
      - src/rvfi_chk_top.sv
  - target: test
    include_dirs:
      - test
    files:
      - test/tb_rvfi_chk.sv
